// File: logic/proto_pkg.sv
package proto_pkg;

	// command ids as they arrive on the byte stream
	typedef logic [7:0] cmd_id_t;

	localparam cmd_id_t CMD_GET_VERSION = 8'd0;
	localparam cmd_id_t CMD_SET_DIGITAL_OUT = 8'd1;
	localparam cmd_id_t CMD_SCHEDULE_DIGITAL_OUT = 8'd2;
	localparam cmd_id_t CMD_QUERY_DIGITAL_OUT = 8'd3;
	localparam int NCMDS = 4;
	localparam int CMD_IDX_BITS = $clog2(NCMDS);	// index width into the command table

	// one decoded argument or one response parameter
	typedef logic signed [31:0] arg_word_t;

	// response ids always go out as the first parameter
	localparam arg_word_t RSP_GET_VERSION = 32'sd0;
	localparam arg_word_t RSP_DOUT_STATE = 32'sd1;

	localparam int MAX_ARGS = 4;
	localparam int ARGS_BITS = $clog2(MAX_ARGS);

	// 32 bits plus 3 bits of sign extension make five 7-bit groups
	localparam int VLQ_GROUPS = 5;

	typedef struct packed {
		logic [ARGS_BITS-1:0] nargs;
		logic has_response;
	} cmdtab_entry_t;

	// indexed by command id
	localparam cmdtab_entry_t CMD_TABLE [NCMDS] = '{
		'{nargs: ARGS_BITS'(0), has_response: 1'b1},	// get_version
		'{nargs: ARGS_BITS'(2), has_response: 1'b0},	// set: channel, level
		'{nargs: ARGS_BITS'(3), has_response: 1'b0},	// schedule: channel, clock, level
		'{nargs: ARGS_BITS'(1), has_response: 1'b1}	// query: channel
	};

endpackage

// File: logic/dout_pkg.sv
package dout_pkg;

	// free running system time, compared against scheduled clocks
	typedef logic [31:0] systime_t;

	// width of the channel select field, at most 16 channels
	localparam int CHAN_BITS = 4;

	// command broadcast from the parser to every channel
	localparam int DOUT_CMD_BITS = 2;
	typedef logic [DOUT_CMD_BITS-1:0] dout_cmd_t;

	localparam dout_cmd_t DOUT_NONE = 2'd0;
	localparam dout_cmd_t DOUT_SET = 2'd1;	// change level at once
	localparam dout_cmd_t DOUT_SCHEDULE = 2'd2;	// change level when systime hits the clock
	localparam dout_cmd_t DOUT_QUERY = 2'd3;	// report the current level

endpackage

// File: logic/cmd_parser.sv
`timescale 1ns/10ps

module cmd_parser #(
	parameter int NCHAN = 4
) (
	input logic clk,
	input logic rst,
	input logic [7:0] msg_data,
	input logic msg_ready,
	input logic rsp_busy,
	output logic msg_rd_en,
	output dout_pkg::dout_cmd_t ch_cmd,
	output logic [dout_pkg::CHAN_BITS-1:0] ch_sel,
	output logic ch_level,
	output dout_pkg::systime_t ch_clock,
	output logic ver_req
);
	import proto_pkg::*;
	import dout_pkg::*;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_ARG_START = 3'd1;
	localparam logic [2:0] ST_ARG_CONT = 3'd2;
	localparam logic [2:0] ST_ARG_END = 3'd3;
	localparam logic [2:0] ST_DISPATCH = 3'd4;

	logic [2:0] state;
	logic [ARGS_BITS-1:0] curr_arg;
	logic [1:0] hold_cnt;	// covers the gap until the encoder raises rsp_busy

	cmd_id_t cur_cmd;
	logic [ARGS_BITS-1:0] cur_nargs;
	logic cur_has_rsp;
	arg_word_t tmp_arg;
	arg_word_t args [MAX_ARGS];

	cmdtab_entry_t tab_entry;
	logic rsp_block;
	logic pop_ok;
	logic dispatch_go;
	logic sel_ok;

	// ids beyond the table read as zero arguments without response, so they fall through
	always_comb begin
		tab_entry = '0;
		if (msg_data < NCMDS)
			tab_entry = CMD_TABLE[msg_data[CMD_IDX_BITS-1:0]];
	end

	assign rsp_block = cur_has_rsp && (rsp_busy || hold_cnt != 2'd0);

	// no argument bytes are taken for a response command while the encoder is still busy
	assign pop_ok = (state == ST_IDLE) || (state == ST_ARG_CONT) ||
		(state == ST_ARG_START && !rsp_block);
	assign dispatch_go = (state == ST_DISPATCH) && !rsp_block;

	// channel numbers wider than the select field must not alias a real channel
	assign sel_ok = (args[0][31:CHAN_BITS] == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			curr_arg <= '0;
			hold_cnt <= 2'd0;
			msg_rd_en <= 1'b0;
			ch_cmd <= DOUT_NONE;
			ver_req <= 1'b0;
		end else begin
			msg_rd_en <= 1'b0;
			ch_cmd <= DOUT_NONE;
			ver_req <= 1'b0;
			if (hold_cnt != 2'd0)
				hold_cnt <= hold_cnt - 2'd1;

			if (msg_rd_en) begin	// the byte under msg_rd_en is taken at this edge
				case (state)
					ST_IDLE: begin
						curr_arg <= '0;
						state <= (tab_entry.nargs == '0) ? ST_DISPATCH : ST_ARG_START;
					end
					ST_ARG_START: state <= msg_data[7] ? ST_ARG_CONT : ST_ARG_END;
					ST_ARG_CONT: begin
						if (!msg_data[7])
							state <= ST_ARG_END;
					end
					default: ;
				endcase
			end else if (msg_ready && pop_ok) begin
				msg_rd_en <= 1'b1;
			end

			if (state == ST_ARG_END) begin
				curr_arg <= curr_arg + 1'b1;
				state <= (curr_arg + 1'b1 == cur_nargs) ? ST_DISPATCH : ST_ARG_START;
			end

			if (dispatch_go) begin
				case (cur_cmd)
					CMD_GET_VERSION: ver_req <= 1'b1;
					CMD_SET_DIGITAL_OUT: ch_cmd <= sel_ok ? DOUT_SET : DOUT_NONE;
					CMD_SCHEDULE_DIGITAL_OUT: ch_cmd <= sel_ok ? DOUT_SCHEDULE : DOUT_NONE;
					CMD_QUERY_DIGITAL_OUT: ch_cmd <= sel_ok ? DOUT_QUERY : DOUT_NONE;
					default: ;
				endcase
				if (cur_has_rsp)
					hold_cnt <= 2'd3;
				state <= ST_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (msg_rd_en) begin
			case (state)
				ST_IDLE: begin
					cur_cmd <= msg_data;
					cur_nargs <= tab_entry.nargs;
					cur_has_rsp <= tab_entry.has_response;
				end
				// first group decides the sign when bits 6 and 5 are both set
				ST_ARG_START: tmp_arg <= {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
				ST_ARG_CONT: tmp_arg <= {tmp_arg[24:0], msg_data[6:0]};
				default: ;
			endcase
		end
		if (state == ST_ARG_END)
			args[curr_arg] <= tmp_arg;
		if (dispatch_go) begin
			ch_sel <= args[0][CHAN_BITS-1:0];
			// the level sits behind the clock for a schedule
			ch_level <= (cur_cmd == CMD_SCHEDULE_DIGITAL_OUT) ? args[2][0] : args[1][0];
			ch_clock <= systime_t'(args[1]);
		end
	end

	a_rd_en_spaced: assert property (@(posedge clk) disable iff (rst)
		msg_rd_en |=> !msg_rd_en);

	// the hold count has to bridge the gap until the encoder reports busy
	a_query_busy: assert property (@(posedge clk) disable iff (rst)
		(ch_cmd == DOUT_QUERY && ch_sel < NCHAN) |-> ##2 rsp_busy);

endmodule

// File: logic/dout_channel.sv
`timescale 1ns/10ps

module dout_channel #(
	parameter int CHAN_INDEX = 0
) (
	input logic clk,
	input logic rst,
	input dout_pkg::systime_t systime,
	input dout_pkg::dout_cmd_t ch_cmd,
	input logic [dout_pkg::CHAN_BITS-1:0] ch_sel,
	input logic ch_level,
	input dout_pkg::systime_t ch_clock,
	output logic dout,
	output logic q_valid,
	output logic q_level
);
	import dout_pkg::*;

	logic hit;
	logic armed;
	systime_t pend_clock;
	logic pend_level;

	// every channel sees the broadcast, only the addressed one reacts
	assign hit = (ch_sel == CHAN_BITS'(CHAN_INDEX));

	always_ff @(posedge clk) begin
		if (rst) begin
			dout <= 1'b0;
			armed <= 1'b0;
			q_valid <= 1'b0;
		end else begin
			q_valid <= hit && (ch_cmd == DOUT_QUERY);

			if (armed && systime == pend_clock) begin
				dout <= pend_level;
				armed <= 1'b0;
			end

			// a set leaves a pending schedule in place
			if (hit && ch_cmd == DOUT_SET)
				dout <= ch_level;

			if (hit && ch_cmd == DOUT_SCHEDULE)
				armed <= 1'b1;	// replaces any schedule still pending
		end
	end

	always_ff @(posedge clk) begin
		if (hit && ch_cmd == DOUT_SCHEDULE) begin
			pend_clock <= ch_clock;
			pend_level <= ch_level;
		end
		if (hit && ch_cmd == DOUT_QUERY)
			q_level <= dout;	// level as it was when the query arrived
	end

	a_query_answer: assert property (@(posedge clk) disable iff (rst)
		q_valid |-> $past(hit && ch_cmd == DOUT_QUERY));

endmodule

// File: logic/rsp_encoder.sv
`timescale 1ns/10ps

module rsp_encoder #(
	parameter int NCHAN = 4,
	parameter logic [31:0] VERSION = 32'h0
) (
	input logic clk,
	input logic rst,
	input logic ver_req,
	input logic [NCHAN-1:0] q_valid,
	input logic [NCHAN-1:0] q_level,
	input logic send_ring_full,
	input logic send_fifo_full,
	output logic rsp_busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en
);
	import proto_pkg::*;
	import dout_pkg::*;

	localparam int MAX_PARAMS = 3;

	localparam logic [2:0] ST_IDLE = 3'd0;
	localparam logic [2:0] ST_PARAM = 3'd1;
	localparam logic [2:0] ST_SKIP = 3'd2;
	localparam logic [2:0] ST_SEND = 3'd3;
	localparam logic [2:0] ST_LEN = 3'd4;

	logic [2:0] state;

	arg_word_t params [MAX_PARAMS];
	logic [1:0] nparams;
	logic [1:0] curr_param;
	logic [34:0] rcv;	// parameter with 3 bits of sign extension, top group first
	logic [2:0] grp_cnt;
	logic [7:0] rsp_len;

	logic [CHAN_BITS-1:0] q_chan;
	logic q_lvl;
	logic skip_group;
	logic last_group;
	logic last_param;

	// the answering channel is known only by its bit position
	always_comb begin
		q_chan = '0;
		q_lvl = 1'b0;
		for (int i = 0; i < NCHAN; i++) begin
			if (q_valid[i]) begin
				q_chan = CHAN_BITS'(i);
				q_lvl = q_level[i];
			end
		end
	end

	// a leading group is dropped when it only repeats the sign of the next one
	assign skip_group = (grp_cnt != 3'd1) &&
		(rcv[34:26] == 9'h1ff || rcv[34:26] < 9'd3);
	assign last_group = (grp_cnt == 3'd1);
	assign last_param = (curr_param + 2'd1 == nparams);

	assign rsp_busy = (state != ST_IDLE);
	assign send_ring_wr_en = (state == ST_SEND) && !send_ring_full;
	assign send_ring_data = {!last_group, rcv[34:28]};	// continuation bit on all but the last
	assign send_fifo_wr_en = (state == ST_LEN) && !send_fifo_full;
	assign send_fifo_data = rsp_len;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ver_req || q_valid != '0)
						state <= ST_PARAM;
				end
				ST_PARAM: state <= ST_SKIP;
				ST_SKIP: begin
					if (!skip_group)
						state <= ST_SEND;
				end
				ST_SEND: begin
					if (send_ring_wr_en && last_group)
						state <= last_param ? ST_LEN : ST_PARAM;
				end
				ST_LEN: begin
					if (!send_fifo_full)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				curr_param <= 2'd0;
				rsp_len <= 8'd0;
				if (ver_req) begin
					params[0] <= RSP_GET_VERSION;
					params[1] <= VERSION;
					nparams <= 2'd2;
				end else begin
					params[0] <= RSP_DOUT_STATE;
					params[1] <= arg_word_t'(q_chan);
					params[2] <= arg_word_t'(q_lvl);
					nparams <= 2'd3;
				end
			end
			ST_PARAM: begin
				rcv <= {{3{params[curr_param][31]}}, params[curr_param]};
				grp_cnt <= 3'(VLQ_GROUPS);
			end
			ST_SKIP: begin
				if (skip_group) begin
					rcv <= {rcv[27:0], 7'b0};
					grp_cnt <= grp_cnt - 3'd1;
				end
			end
			ST_SEND: begin
				if (send_ring_wr_en) begin
					rcv <= {rcv[27:0], 7'b0};
					grp_cnt <= grp_cnt - 3'd1;
					rsp_len <= rsp_len + 8'd1;
					if (last_group)
						curr_param <= curr_param + 2'd1;
				end
			end
			default: ;
		endcase
	end

	a_ring_not_full: assert property (@(posedge clk) disable iff (rst)
		!(send_ring_wr_en && send_ring_full));

	// channels answer one query at a time since the parser waits for the response
	a_single_answer: assert property (@(posedge clk) disable iff (rst)
		$onehot0(q_valid));

endmodule

// File: logic/dout_ctrl_top.sv
`timescale 1ns/10ps

module dout_ctrl_top #(
	parameter int NCHAN = 4,	// 1 to 16
	parameter logic [31:0] VERSION = 32'h0
) (
	input logic clk,
	input logic rst,
	input logic [7:0] msg_data,
	input logic msg_ready,
	input dout_pkg::systime_t systime,
	input logic send_ring_full,
	input logic send_fifo_full,
	output logic msg_rd_en,
	output logic [NCHAN-1:0] dout,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en
);
	import dout_pkg::*;

	dout_cmd_t ch_cmd;
	logic [CHAN_BITS-1:0] ch_sel;
	logic ch_level;
	systime_t ch_clock;
	logic ver_req;
	logic rsp_busy;
	logic [NCHAN-1:0] q_valid;
	logic [NCHAN-1:0] q_level;

	cmd_parser #(
		.NCHAN(NCHAN)
	) u_parser (
		.clk(clk),
		.rst(rst),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.rsp_busy(rsp_busy),
		.msg_rd_en(msg_rd_en),
		.ch_cmd(ch_cmd),
		.ch_sel(ch_sel),
		.ch_level(ch_level),
		.ch_clock(ch_clock),
		.ver_req(ver_req)
	);

	// each channel knows its own index and filters the broadcast itself
	for (genvar i = 0; i < NCHAN; i++) begin : g_chan
		dout_channel #(
			.CHAN_INDEX(i)
		) u_chan (
			.clk(clk),
			.rst(rst),
			.systime(systime),
			.ch_cmd(ch_cmd),
			.ch_sel(ch_sel),
			.ch_level(ch_level),
			.ch_clock(ch_clock),
			.dout(dout[i]),
			.q_valid(q_valid[i]),
			.q_level(q_level[i])
		);
	end

	rsp_encoder #(
		.NCHAN(NCHAN),
		.VERSION(VERSION)
	) u_encoder (
		.clk(clk),
		.rst(rst),
		.ver_req(ver_req),
		.q_valid(q_valid),
		.q_level(q_level),
		.send_ring_full(send_ring_full),
		.send_fifo_full(send_fifo_full),
		.rsp_busy(rsp_busy),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_PERIOD = 10,	// 20 ns clock period
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset is released on a rising edge so the DUT sees it synchronously
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// File: dv/tb_dout_ctrl.sv
`timescale 1ns/10ps

module tb_dout_ctrl;
	import proto_pkg::*;

	localparam int NCHAN = 4;
	localparam logic [31:0] VERSION = 32'hc0de_0402;	// negative as a signed word, needs 5 bytes
	localparam int N_CMDS = 40;
	localparam int IDLE_LIMIT = 6000;
	localparam int TIME_LIMIT = 2000;

	logic clk;
	logic rst;
	logic [7:0] msg_data = 8'h00;
	logic msg_ready = 1'b0;
	logic [31:0] systime = 32'd0;
	logic send_ring_full = 1'b0;
	logic send_fifo_full = 1'b0;
	logic msg_rd_en;
	logic [NCHAN-1:0] dout;
	logic [7:0] send_ring_data;
	logic send_ring_wr_en;
	logic [7:0] send_fifo_data;
	logic send_fifo_wr_en;

	integer seed = 32'hd8c8;
	logic bp_on = 1'b0;	// random ring and FIFO full while set

	logic [7:0] byte_q [$];	// command bytes not yet consumed by the parser
	logic [7:0] exp_q [$];	// response bytes still expected on the ring
	logic [7:0] exp_len_q [$];
	logic [7:0] vlq_buf [$];

	logic [NCHAN-1:0] model_level = '0;
	logic [NCHAN-1:0] pend_armed = '0;
	logic [NCHAN-1:0] pend_level = '0;
	logic [31:0] pend_clock [NCHAN];

	tb_clock u_clock (
		.clk(clk),
		.rst(rst)
	);

	dout_ctrl_top #(
		.NCHAN(NCHAN),
		.VERSION(VERSION)
	) u_dout_ctrl_top (
		.clk(clk),
		.rst(rst),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.systime(systime),
		.send_ring_full(send_ring_full),
		.send_fifo_full(send_fifo_full),
		.msg_rd_en(msg_rd_en),
		.dout(dout),
		.send_ring_data(send_ring_data),
		.send_ring_wr_en(send_ring_wr_en),
		.send_fifo_data(send_fifo_data),
		.send_fifo_wr_en(send_fifo_wr_en)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			report_failure($sformatf("** Error %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
	endtask

	// n groups hold values from -32*128^(n-1) up to 96*128^(n-1)-1
	task automatic encode_vlq(input int v);
		longint lo;
		longint hi;
		int n;
		vlq_buf.delete();
		n = 1;
		lo = -32;
		hi = 96;
		while (n < 5 && !(v >= lo && v < hi)) begin
			n++;
			lo = lo * 128;
			hi = hi * 128;
		end
		for (int i = n - 1; i >= 0; i--)
			vlq_buf.push_back({i != 0, 7'((v >>> (7 * i)) & 127)});
	endtask

	task automatic put_arg(input int v);
		encode_vlq(v);
		foreach (vlq_buf[i])
			byte_q.push_back(vlq_buf[i]);
	endtask

	task automatic expect_rsp(input int nparams, input int p0, input int p1, input int p2);
		int vals [3];
		int len;
		vals = '{p0, p1, p2};
		len = 0;
		for (int k = 0; k < nparams; k++) begin
			encode_vlq(vals[k]);
			foreach (vlq_buf[i])
				exp_q.push_back(vlq_buf[i]);
			len += vlq_buf.size();
		end
		exp_len_q.push_back(8'(len));
	endtask

	function automatic void update_model();
		for (int c = 0; c < NCHAN; c++) begin
			if (pend_armed[c] && systime > pend_clock[c]) begin
				model_level[c] = pend_level[c];
				pend_armed[c] = 1'b0;
			end
		end
	endfunction

	task automatic cmd_version();
		byte_q.push_back(CMD_GET_VERSION);
		expect_rsp(2, RSP_GET_VERSION, VERSION, 0);
	endtask

	task automatic cmd_set(input int ch, input int lvl);
		byte_q.push_back(CMD_SET_DIGITAL_OUT);
		put_arg(ch);
		put_arg(lvl);
		if (ch >= 0 && ch < NCHAN)
			model_level[ch] = lvl[0];	// channels beyond the bank ignore the command
	endtask

	task automatic cmd_schedule(input int ch, input logic [31:0] when, input int lvl);
		byte_q.push_back(CMD_SCHEDULE_DIGITAL_OUT);
		put_arg(ch);
		put_arg(int'(when));
		put_arg(lvl);
		pend_armed[ch] = 1'b1;
		pend_clock[ch] = when;
		pend_level[ch] = lvl[0];
	endtask

	task automatic cmd_query(input int ch, input bit padded);
		byte_q.push_back(CMD_QUERY_DIGITAL_OUT);
		if (padded) begin
			byte_q.push_back(8'h80);	// two empty groups ahead of the real one
			byte_q.push_back(8'h80);
			byte_q.push_back(8'(ch));
		end else begin
			put_arg(ch);
		end
		update_model();
		expect_rsp(3, RSP_DOUT_STATE, ch, int'(model_level[ch]));
	endtask

	task automatic wait_idle(input string what);
		int n;
		n = 0;
		while (byte_q.size() != 0 || exp_len_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > IDLE_LIMIT)
				report_failure({"timed out waiting for the DUT to finish ", what});
		end
		repeat (8) @(negedge clk);	// room for the last dispatch to reach dout
	endtask

	task automatic wait_until(input logic [31:0] t);
		int n;
		n = 0;
		while (systime < t) begin
			@(negedge clk);
			update_model();
			n++;
			if (n > TIME_LIMIT)
				report_failure("timed out waiting for the system time to advance");
		end
	endtask

	task automatic check_dout(input string name);
		update_model();
		check_value(name, 32'(model_level), 32'(dout));
	endtask

	always @(posedge clk) begin
		if (rst)
			systime <= 32'd0;
		else
			systime <= systime + 32'd1;
	end

	// the front byte stays on msg_data until the parser pops it
	always @(posedge clk) begin
		if (rst) begin
			msg_ready <= 1'b0;
		end else begin
			if (msg_rd_en) begin
				if (byte_q.size() == 0)
					report_failure("the parser took a byte while none was offered");
				else
					void'(byte_q.pop_front());
			end
			msg_ready <= (byte_q.size() != 0);
			if (byte_q.size() != 0)
				msg_data <= byte_q[0];
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			send_ring_full <= 1'b0;
			send_fifo_full <= 1'b0;
		end else begin
			send_ring_full <= bp_on && (($random(seed) & 3) == 0);
			send_fifo_full <= bp_on && (($random(seed) & 1) == 1);
			if (send_ring_wr_en) begin
				if (send_ring_full)
					report_failure("a ring byte was written while the ring was full");
				else if (exp_q.size() == 0)
					report_failure("a response byte arrived with no response pending");
				else
					check_value("ring byte", 32'(exp_q.pop_front()), 32'(send_ring_data));
			end
			if (send_fifo_wr_en) begin
				if (send_fifo_full)
					report_failure("a response length was written while the FIFO was full");
				else if (exp_len_q.size() == 0)
					report_failure("a response length arrived with no response pending");
				else
					check_value("response length", 32'(exp_len_q.pop_front()),
						32'(send_fifo_data));
			end
		end
	end

	initial begin
		int n;
		int ch;
		logic old;
		logic [31:0] t1;
		logic [31:0] t2;

		n = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > 20)
				report_failure("reset was never released");
		end

		cmd_version();
		wait_idle("the get_version response");
		check_dout("dout after reset");

		for (int k = 0; k < 16; k++) begin
			ch = {$random(seed)} % 6;	// 4 and 5 match no channel
			cmd_set(ch, {$random(seed)} % 4);
			if (k % 4 == 3) begin
				wait_idle("set_digital_out");
				check_dout("dout after set");
			end
		end
		cmd_set(-3, 1);
		cmd_set(200, 1);
		wait_idle("out-of-range sets");
		check_dout("dout after out-of-range set");

		// a far schedule must stay pending
		cmd_query(2, 1'b1);
		old = model_level[1];
		cmd_schedule(1, 32'h1000_0000, int'(!old));
		wait_idle("the padded query");
		wait_until(systime + 32'd40);
		check_dout("dout with far schedule");

		t1 = systime + 32'd80;
		t2 = systime + 32'd140;
		cmd_schedule(1, t1, int'(!old));
		cmd_schedule(1, t2, int'(!old));	// replaces the one at t1
		wait_until(t1 + 32'd2);
		check_dout("dout after replaced schedule");
		wait_until(t2);
		check_dout("dout before schedule");
		wait_until(t2 + 32'd2);
		check_dout("dout after schedule");

		bp_on = 1'b1;
		for (int k = 0; k < N_CMDS; k++) begin
			ch = {$random(seed)} % NCHAN;
			if ({$random(seed)} % 2 == 0)
				cmd_query(ch, 1'b0);
			else
				cmd_set(ch, {$random(seed)} % 2);
		end
		cmd_version();
		wait_idle("commands under back-pressure");
		check_dout("dout after mixed commands");
		bp_on = 1'b0;
		check_value("unmatched response bytes", 32'd0, 32'(exp_q.size()));

		$display("TEST OK");
		$finish;
	end

endmodule

// File: files.f
logic/proto_pkg.sv
logic/dout_pkg.sv
logic/cmd_parser.sv
logic/dout_channel.sv
logic/rsp_encoder.sv
logic/dout_ctrl_top.sv
dv/tb_clock.sv
dv/tb_dout_ctrl.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_dout_ctrl -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
